/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_quant_unit_top
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/quant_matrix.sv */
/*
 * Quantizer matrix builder
 * Derives per-coefficient reciprocal, bias, zero threshold and sharpening
 * from the DC and AC steps, running four divisions on one divider
 */
module quant_matrix
    import vp8_quant_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_start_i,
    input  logic [COEFF_W-1:0] q_dc_i,
    input  logic [COEFF_W-1:0] q_ac_i,
    input  block_type_e        blk_type_i,
    output logic               cfg_busy_o,
    output logic               cfg_done_o,
    output qval_blk_t          q_mat_o,
    output qval_blk_t          iq_mat_o,
    output qval_blk_t          sharpen_mat_o,
    output wide_blk_t          bias_mat_o,
    output wide_blk_t          zth_mat_o
);

    matrix_state_e      state;
    logic               div_start;
    logic               div_done;
    logic [DIV_W-1:0]   dividend;
    logic [DIV_W-1:0]   divisor;
    logic [DIV_W-1:0]   quotient;
    logic [COEFF_W-1:0] iq_sat;
    logic [COEFF_W-1:0] q_dc_r;
    logic [COEFF_W-1:0] q_ac_r;
    logic [COEFF_W-1:0] iq_dc_r;
    logic [COEFF_W-1:0] iq_ac_r;
    logic [DIV_W-1:0]   zt_dc_r;
    block_type_e        type_r;
    logic [31:0]        bias_dc;
    logic [31:0]        bias_ac;
    logic               load_mat;
    qval_blk_t          q_nxt;
    qval_blk_t          iq_nxt;
    qval_blk_t          sharp_nxt;
    wide_blk_t          bias_nxt;
    wide_blk_t          zth_nxt;

    assign cfg_busy_o = (state != MX_IDLE);
    assign load_mat   = (state == MX_ZT_AC) && div_done;
    assign bias_dc    = 32'(BIAS_DC[type_r]) << BIAS_SHIFT;
    assign bias_ac    = 32'(BIAS_AC[type_r]) << BIAS_SHIFT;

    // Steps of 1 and 2 give a reciprocal past 16 bits, so it saturates
    assign iq_sat = (|quotient[DIV_W-1:COEFF_W]) ? '1 : quotient[COEFF_W-1:0];

    // ----------------------------------------
    // Division sequencer
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= MX_IDLE;
            div_start  <= 1'b0;
            cfg_done_o <= 1'b0;
        end else begin
            div_start  <= 1'b0;
            cfg_done_o <= 1'b0;
            case (state)
                MX_IDLE: begin
                    if (cfg_start_i) begin
                        state     <= MX_IQ_DC;
                        div_start <= 1'b1;
                    end
                end
                MX_IQ_DC: begin
                    if (div_done) begin
                        state     <= MX_IQ_AC;
                        div_start <= 1'b1;
                    end
                end
                MX_IQ_AC: begin
                    if (div_done) begin
                        state     <= MX_ZT_DC;
                        div_start <= 1'b1;
                    end
                end
                MX_ZT_DC: begin
                    if (div_done) begin
                        state     <= MX_ZT_AC;
                        div_start <= 1'b1;
                    end
                end
                MX_ZT_AC: begin
                    if (div_done) begin
                        state      <= MX_IDLE;
                        cfg_done_o <= 1'b1;
                    end
                end
                default: state <= MX_IDLE;
            endcase
        end
    end

    // Operands: 2^QFIX / q first, then (2^QFIX - 1 - bias) / iq
    always_comb begin
        dividend = DIV_W'(1 << QFIX);
        divisor  = DIV_W'(q_dc_r);
        case (state)
            MX_IQ_AC: divisor = DIV_W'(q_ac_r);
            MX_ZT_DC: begin
                dividend = DIV_W'((1 << QFIX) - 1) - bias_dc[DIV_W-1:0];
                divisor  = DIV_W'(iq_dc_r);
            end
            MX_ZT_AC: begin
                dividend = DIV_W'((1 << QFIX) - 1) - bias_ac[DIV_W-1:0];
                divisor  = DIV_W'(iq_ac_r);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if ((state == MX_IDLE) && cfg_start_i) begin
            q_dc_r <= q_dc_i;
            q_ac_r <= q_ac_i;
            type_r <= blk_type_i;
        end
        if (div_done) begin
            case (state)
                MX_IQ_DC: iq_dc_r <= iq_sat;
                MX_IQ_AC: iq_ac_r <= iq_sat;
                MX_ZT_DC: zt_dc_r <= quotient;
                default: ;
            endcase
        end
    end

    seq_divider u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (div_start),
        .dividend_i (dividend),
        .divisor_i  (divisor),
        .quotient_o (quotient),
        .done_o     (div_done)
    );

    // ----------------------------------------
    // Matrix expansion
    // ----------------------------------------
    // Entry 0 is DC, the rest share the AC terms
    always_comb begin
        logic [COEFF_W-1:0] q_sel;
        logic [31:0]        sharp_prod;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            q_sel        = (i == 0) ? q_dc_r : q_ac_r;
            q_nxt[i]     = q_sel;
            iq_nxt[i]    = (i == 0) ? iq_dc_r : iq_ac_r;
            bias_nxt[i]  = (i == 0) ? bias_dc : bias_ac;
            zth_nxt[i]   = (i == 0) ? 32'(zt_dc_r) : 32'(quotient);
            sharp_prod   = 32'(FREQ_SHARPEN[i]) * 32'(q_sel);
            sharp_nxt[i] = (type_r == BLK_Y1) ? sharp_prod[SHARPEN_SHIFT +: COEFF_W] : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_mat_o       <= '0;
            iq_mat_o      <= '0;
            sharpen_mat_o <= '0;
            bias_mat_o    <= '0;
            zth_mat_o     <= '0;
        end else if (load_mat) begin
            q_mat_o       <= q_nxt;
            iq_mat_o      <= iq_nxt;
            sharpen_mat_o <= sharp_nxt;
            bias_mat_o    <= bias_nxt;
            zth_mat_o     <= zth_nxt;
        end
    end

endmodule

/* logic/quant_unit_top.sv */
/*
 * Coefficient quantizer top level
 * Matrix builder feeding the pipelined block quantizer
 */
module quant_unit_top
    import vp8_quant_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_start_i,
    input  logic [COEFF_W-1:0] q_dc_i,
    input  logic [COEFF_W-1:0] q_ac_i,
    input  block_type_e        blk_type_i,
    output logic               cfg_busy_o,
    output logic               cfg_done_o,
    input  logic               start_i,
    input  coeff_blk_t         coeff_i,
    output coeff_blk_t         level_o,
    output coeff_blk_t         recon_o,
    output logic               nz_o,
    output logic               done_o
);

    // Stable whenever the matrix builder is idle
    qval_blk_t q_mat;
    qval_blk_t iq_mat;
    qval_blk_t sharpen_mat;
    wide_blk_t bias_mat;
    wide_blk_t zth_mat;

    quant_matrix u_matrix (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_start_i   (cfg_start_i),
        .q_dc_i        (q_dc_i),
        .q_ac_i        (q_ac_i),
        .blk_type_i    (blk_type_i),
        .cfg_busy_o    (cfg_busy_o),
        .cfg_done_o    (cfg_done_o),
        .q_mat_o       (q_mat),
        .iq_mat_o      (iq_mat),
        .sharpen_mat_o (sharpen_mat),
        .bias_mat_o    (bias_mat),
        .zth_mat_o     (zth_mat)
    );

    quantize_block u_quant (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .coeff_i       (coeff_i),
        .q_mat_i       (q_mat),
        .iq_mat_i      (iq_mat),
        .sharpen_mat_i (sharpen_mat),
        .bias_mat_i    (bias_mat),
        .zth_mat_i     (zth_mat),
        .level_o       (level_o),
        .recon_o       (recon_o),
        .nz_o          (nz_o),
        .done_o        (done_o)
    );

endmodule

/* logic/quantize_block.sv */
/*
 * 4x4 block quantizer, two pipeline stages
 * Levels leave in zigzag order, reconstruction in raster order
 */
module quantize_block
    import vp8_quant_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  coeff_blk_t coeff_i,
    input  qval_blk_t  q_mat_i,
    input  qval_blk_t  iq_mat_i,
    input  qval_blk_t  sharpen_mat_i,
    input  wide_blk_t  bias_mat_i,
    input  wide_blk_t  zth_mat_i,
    output coeff_blk_t level_o,
    output coeff_blk_t recon_o,
    output logic       nz_o,
    output logic       done_o
);

    logic                                     s1_valid;
    logic [NUM_COEFFS-1:0]                    sign_s1;
    logic [NUM_COEFFS-1:0][MAG_W-1:0]         mag_s1;
    logic [NUM_COEFFS-1:0][SCALED_W-QFIX-1:0] lvl_s1;
    logic [NUM_COEFFS-1:0]                    sign_r;
    logic [NUM_COEFFS-1:0][MAG_W-1:0]         mag_r;
    logic [NUM_COEFFS-1:0][SCALED_W-QFIX-1:0] lvl_r;
    coeff_blk_t                               lvl_nxt;
    coeff_blk_t                               rec_nxt;
    logic                                     nz_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            s1_valid <= start_i;
            done_o   <= s1_valid;
        end
    end

    // ----------------------------------------
    // Stage one: sharpened magnitude and scale
    // ----------------------------------------
    always_comb begin
        logic [MAG_W-1:0]    ext;
        logic [SCALED_W-1:0] scaled;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            sign_s1[i] = coeff_i[i][COEFF_W-1];
            ext        = {coeff_i[i][COEFF_W-1], coeff_i[i]};
            mag_s1[i]  = (sign_s1[i] ? -ext : ext) + MAG_W'(sharpen_mat_i[i]);
            scaled     = SCALED_W'(mag_s1[i]) * SCALED_W'(iq_mat_i[i])
                       + SCALED_W'(bias_mat_i[i]);
            lvl_s1[i]  = scaled[SCALED_W-1:QFIX];
        end
    end

    // Sign and magnitude travel with the level so coeff_i can change
    always_ff @(posedge clk) begin
        if (start_i) begin
            sign_r <= sign_s1;
            mag_r  <= mag_s1;
            lvl_r  <= lvl_s1;
        end
    end

    // ----------------------------------------
    // Stage two: clamp, threshold, reconstruct
    // ----------------------------------------
    always_comb begin
        logic [COEFF_W-1:0]   mag_lim;
        logic [2*COEFF_W-1:0] prod;
        nz_nxt = 1'b0;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            mag_lim = (int'(lvl_r[i]) > MAX_LEVEL) ? COEFF_W'(MAX_LEVEL)
                                                   : lvl_r[i][COEFF_W-1:0];
            if (32'(mag_r[i]) > zth_mat_i[i]) begin
                lvl_nxt[i] = sign_r[i] ? -mag_lim : mag_lim;
            end else begin
                lvl_nxt[i] = '0;
            end
            // Low half of the product is the same signed or unsigned
            prod       = lvl_nxt[i] * q_mat_i[i];
            rec_nxt[i] = prod[COEFF_W-1:0];
            nz_nxt     = nz_nxt | (lvl_nxt[i] != '0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_o <= '0;
            recon_o <= '0;
            nz_o    <= 1'b0;
        end else if (s1_valid) begin
            for (int k = 0; k < NUM_COEFFS; k++) begin
                level_o[k] <= lvl_nxt[ZIGZAG[k]];
            end
            recon_o <= rec_nxt;
            nz_o    <= nz_nxt;
        end
    end

endmodule

/* logic/seq_divider.sv */
/*
 * Sequential restoring divider
 * Unsigned, one quotient bit per cycle, start and done strobes
 */
module seq_divider
    import vp8_quant_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_i,
    input  logic [DIV_W-1:0] dividend_i,
    input  logic [DIV_W-1:0] divisor_i,
    output logic [DIV_W-1:0] quotient_o,
    output logic             done_o
);

    logic                 running;
    logic [DIV_CNT_W-1:0] cnt;
    logic [DIV_W:0]       rem;
    logic [DIV_W-1:0]     dvsr;
    logic [DIV_W:0]       rem_shift;
    logic [DIV_W+1:0]     diff;

    // Bring down the next dividend bit and try the subtraction
    assign rem_shift = {rem[DIV_W-1:0], quotient_o[DIV_W-1]};
    assign diff      = {1'b0, rem_shift} - {2'b00, dvsr};

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == DIV_CNT_W'(DIV_W - 1)) begin
                    running <= 1'b0;
                    done_o  <= 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    // Quotient bits shift in where the dividend shifts out
    always_ff @(posedge clk) begin
        if (start_i) begin
            rem        <= '0;
            dvsr       <= divisor_i;
            quotient_o <= dividend_i;
        end else if (running) begin
            if (diff[DIV_W+1]) begin
                rem        <= rem_shift;
                quotient_o <= {quotient_o[DIV_W-2:0], 1'b0};
            end else begin
                rem        <= diff[DIV_W:0];
                quotient_o <= {quotient_o[DIV_W-2:0], 1'b1};
            end
        end
    end

endmodule

/* logic/vp8_quant_pkg.sv */
/*
 * VP8 coefficient quantizer definitions
 * Block geometry, fixed-point widths, lookup tables and state enums
 */
package vp8_quant_pkg;

    // ----------------------------------------
    // Geometry and fixed point
    // ----------------------------------------
    localparam int NUM_COEFFS    = 16;
    localparam int COEFF_W       = 16;
    localparam int QFIX          = 17;
    localparam int MAX_LEVEL     = 2047;
    localparam int BIAS_SHIFT    = 9;
    localparam int SHARPEN_SHIFT = 11;
    // Sharpened magnitude, then magnitude x iq + bias
    localparam int MAG_W         = COEFF_W + 1;
    localparam int SCALED_W      = MAG_W + COEFF_W + 1;
    localparam int DIV_W         = 18;
    localparam int DIV_CNT_W     = $clog2(DIV_W);

    typedef logic signed [COEFF_W-1:0] coeff_t;
    typedef coeff_t [NUM_COEFFS-1:0] coeff_blk_t;
    typedef logic [NUM_COEFFS-1:0][COEFF_W-1:0] qval_blk_t;
    typedef logic [NUM_COEFFS-1:0][31:0] wide_blk_t;

    typedef enum logic [1:0] {BLK_Y1, BLK_Y2, BLK_UV} block_type_e;

    typedef enum logic [2:0] {MX_IDLE, MX_IQ_DC, MX_IQ_AC, MX_ZT_DC, MX_ZT_AC} matrix_state_e;

    // ----------------------------------------
    // Tables
    // ----------------------------------------
    // Raster index for each output position
    localparam int ZIGZAG [NUM_COEFFS] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    // Rounding bias bytes, indexed by block type
    localparam logic [7:0] BIAS_DC [3] = '{8'd96, 8'd96, 8'd110};
    localparam logic [7:0] BIAS_AC [3] = '{8'd110, 8'd108, 8'd115};

    // Raster-order sharpening weights, Y1 only
    localparam int FREQ_SHARPEN [NUM_COEFFS] = '{0, 30, 60, 90, 30, 60, 90, 90,
                                                 60, 90, 90, 90, 90, 90, 90, 90};

endpackage

/* verif/quant_unit_properties.sv */
/*
 * Strobe timing and sequencing checks for the quantizer top level
 */
module quant_unit_properties
    import vp8_quant_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       cfg_start_i,
    input logic       cfg_busy_o,
    input logic       cfg_done_o,
    input logic       start_i,
    input logic       done_o,
    input logic       nz_o,
    input coeff_blk_t level_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // Set once the first matrix set is loaded
    logic configured;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            configured <= 1'b0;
        end else if (cfg_done_o) begin
            configured <= 1'b1;
        end
    end

    a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> ##2 done_o)
        else $error("done_o did not follow start_i by two cycles");

    a_cfg_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_start_i && !cfg_busy_o) |-> ##81 cfg_done_o)
        else $error("cfg_done_o did not follow cfg_start_i by 81 cycles");

    a_start_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> (!cfg_busy_o && (configured || cfg_done_o)))
        else $error("start_i while the matrix unit is busy or unconfigured");

    a_nz_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (level_o == '0) |-> !nz_o)
        else $error("nz_o high with every level zero");

endmodule

bind quant_unit_top quant_unit_properties u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_start_i (cfg_start_i),
    .cfg_busy_o  (cfg_busy_o),
    .cfg_done_o  (cfg_done_o),
    .start_i     (start_i),
    .done_o      (done_o),
    .nz_o        (nz_o),
    .level_o     (level_o)
);

/* verif/tb_quant_unit_top.sv */
/*
 * Directed testbench for the coefficient quantizer top level
 * Reference model for matrix terms, levels, zigzag order and reconstruction
 */
module tb_quant_unit_top
    import vp8_quant_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CFG_LATENCY    = 81;
    localparam int MAX_CONFIGS    = 10;
    localparam int MAX_BLOCKS     = 300;
    localparam int TIMEOUT_CYCLES = MAX_CONFIGS * (CFG_LATENCY + 19) + MAX_BLOCKS * 16 + 200;
    localparam int MAX_BURST      = 8;

    // Independent copies of the VP8 tables
    localparam int DC_BIAS [3] = '{96, 96, 110};
    localparam int AC_BIAS [3] = '{110, 108, 115};
    localparam int SHARPEN_WEIGHT [16] = '{0, 30, 60, 90, 30, 60, 90, 90,
                                           60, 90, 90, 90, 90, 90, 90, 90};
    localparam int ZZ_ORDER [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    logic               clk;
    logic               rst_n;
    logic               cfg_start_i;
    logic [COEFF_W-1:0] q_dc_i;
    logic [COEFF_W-1:0] q_ac_i;
    block_type_e        blk_type_i;
    logic               cfg_busy_o;
    logic               cfg_done_o;
    logic               start_i;
    coeff_blk_t         coeff_i;
    coeff_blk_t         level_o;
    coeff_blk_t         recon_o;
    logic               nz_o;
    logic               done_o;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state  = 32'ha569;

    // Model state for the current configuration
    int          m_q [16];
    int          m_iq [16];
    int          m_bias [16];
    int          m_zth [16];
    int          m_sharp [16];
    coeff_blk_t  blk_in [MAX_BURST];
    logic [15:0] exp_lvl [MAX_BURST][16];
    logic [15:0] exp_rec [MAX_BURST][16];
    logic        exp_nz [MAX_BURST];

    quant_unit_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, checks %0d, errors %0d",
                     cycle_count, check_count, error_count + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic int take_bits(input int nbits);
        int v;
        v = 0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic fail(input string what);
        error_count++;
        $display("Error at cycle %0d: %s", cycle_count, what);
    endtask

    task automatic compare_word(input string name, input int idx, input logic [15:0] got,
                                input logic [15:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch %s[%0d]: got 0x%h expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic random_block(input int j, input int nbits);
        int v;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            v = take_bits(nbits);
            if (v >= (1 << (nbits - 1))) v = v - (1 << nbits);
            blk_in[j][i] = 16'(v);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic model_config(input int q_dc, input int q_ac, input block_type_e btype);
        int t;
        t = int'(btype);
        for (int i = 0; i < NUM_COEFFS; i++) begin
            m_q[i]    = (i == 0) ? q_dc : q_ac;
            m_iq[i]   = (1 << 17) / m_q[i];
            // Reciprocal is a 16-bit quantity
            if (m_iq[i] > 65535) m_iq[i] = 65535;
            m_bias[i]  = ((i == 0) ? DC_BIAS[t] : AC_BIAS[t]) << 9;
            m_zth[i]   = ((1 << 17) - 1 - m_bias[i]) / m_iq[i];
            m_sharp[i] = (btype == BLK_Y1) ? (SHARPEN_WEIGHT[i] * m_q[i]) >> 11 : 0;
        end
    endtask

    task automatic predict(input int j);
        int     c;
        int     mag;
        int     lvl;
        longint scaled;
        int     raster_lvl [16];
        exp_nz[j] = 1'b0;
        for (int i = 0; i < NUM_COEFFS; i++) begin
            c      = int'($signed(blk_in[j][i]));
            mag    = ((c < 0) ? -c : c) + m_sharp[i];
            scaled = longint'(mag) * longint'(m_iq[i]) + longint'(m_bias[i]);
            lvl    = int'(scaled >>> 17);
            if (lvl > 2047) lvl = 2047;
            if (mag <= m_zth[i]) lvl = 0;
            if (c < 0) lvl = -lvl;
            raster_lvl[i] = lvl;
            exp_rec[j][i] = 16'(lvl * m_q[i]);
            if (lvl != 0) exp_nz[j] = 1'b1;
        end
        for (int k = 0; k < NUM_COEFFS; k++) begin
            exp_lvl[j][k] = 16'(raster_lvl[ZZ_ORDER[k]]);
        end
    endtask

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic configure(input int q_dc, input int q_ac, input block_type_e btype);
        int cycles;
        int busy_gaps;
        @(posedge clk);
        cfg_start_i <= 1'b1;
        q_dc_i      <= 16'(q_dc);
        q_ac_i      <= 16'(q_ac);
        blk_type_i  <= btype;
        @(posedge clk);
        cfg_start_i <= 1'b0;
        q_dc_i      <= '0;
        q_ac_i      <= '0;
        cycles      = 0;
        busy_gaps   = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!cfg_done_o && !cfg_busy_o) busy_gaps++;
        end while (!cfg_done_o && cycles < CFG_LATENCY + 20);
        check_count++;
        if (!cfg_done_o) begin
            fail("cfg_done_o never arrived after cfg_start_i");
        end else if (cycles != CFG_LATENCY) begin
            error_count++;
            $display("Mismatch cfg latency: got 0x%h expected 0x%h", cycles, CFG_LATENCY);
        end
        if (busy_gaps != 0) fail("cfg_busy_o went low before cfg_done_o");
        model_config(q_dc, q_ac, btype);
    endtask

    // Blocks start on consecutive cycles, results are collected in order
    task automatic send_blocks(input int n);
        int waited;
        for (int j = 0; j < n; j++) predict(j);
        fork
            begin
                for (int j = 0; j < n; j++) begin
                    @(posedge clk);
                    start_i <= 1'b1;
                    coeff_i <= blk_in[j];
                end
                @(posedge clk);
                start_i <= 1'b0;
                coeff_i <= ~blk_in[n-1];
            end
            begin
                for (int j = 0; j < n; j++) begin
                    waited = 0;
                    do begin
                        @(negedge clk);
                        waited++;
                    end while (!done_o && waited < 8);
                    if (!done_o) begin
                        fail($sformatf("done_o missing for block %0d", j));
                    end else begin
                        for (int k = 0; k < NUM_COEFFS; k++) begin
                            compare_word("level_o", k, level_o[k], exp_lvl[j][k]);
                            compare_word("recon_o", k, recon_o[k], exp_rec[j][k]);
                        end
                        compare_word("nz_o", j, 16'(nz_o), 16'(exp_nz[j]));
                    end
                end
            end
        join
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_and_config();
        @(negedge clk);
        check_count++;
        if (cfg_done_o || cfg_busy_o || done_o || nz_o) fail("outputs not low after reset");
        if (level_o != '0 || recon_o != '0) fail("block outputs not zero after reset");
        configure(40, 48, BLK_UV);
        configure(33, 37, BLK_Y2);
        configure(40, 40, BLK_Y1);
    endtask

    task automatic test_zero_blocks();
        blk_in[0] = '0;
        random_block(1, 3);
        send_blocks(2);
        check_count++;
        if (nz_o) fail("nz_o high for a block below zthresh");
    endtask

    task automatic test_random_y1();
        configure(8, 10, BLK_Y1);
        for (int j = 0; j < MAX_BURST; j++) random_block(j, 12);
        send_blocks(MAX_BURST);
        configure(20, 26, BLK_Y1);
        for (int j = 0; j < MAX_BURST; j++) random_block(j, 13);
        send_blocks(MAX_BURST);
        configure(60, 80, BLK_Y1);
        for (int j = 0; j < MAX_BURST; j++) random_block(j, 15);
        send_blocks(MAX_BURST);
    endtask

    task automatic test_clamp();
        int mag;
        configure(2, 3, BLK_Y1);
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < NUM_COEFFS; i++) begin
                if (b == 0) blk_in[0][i] = (i % 2) ? -16'sd30000 : 16'(30000 - i * 100);
                else blk_in[0][i] = (i % 2) ? 16'sh7fff : 16'sh8000;
            end
            send_blocks(1);
            for (int k = 0; k < NUM_COEFFS; k++) begin
                mag = int'($signed(level_o[k]));
                check_count++;
                if (mag != MAX_LEVEL && mag != -MAX_LEVEL) fail("level_o not clamped at 2047");
            end
        end
    endtask

    task automatic test_back_to_back();
        configure(30, 36, BLK_Y1);
        for (int j = 0; j < 6; j++) random_block(j, 14);
        send_blocks(6);
    endtask

    task automatic test_reconfig();
        configure(24, 30, BLK_UV);
        for (int j = 0; j < 6; j++) random_block(j, 13);
        send_blocks(6);
        configure(18, 22, BLK_Y2);
        for (int j = 0; j < 6; j++) random_block(j, 13);
        send_blocks(6);
    endtask

    initial begin
        rst_n       <= 1'b0;
        cfg_start_i <= 1'b0;
        q_dc_i      <= '0;
        q_ac_i      <= '0;
        blk_type_i  <= BLK_Y1;
        start_i     <= 1'b0;
        coeff_i     <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_and_config();
        test_zero_blocks();
        test_random_y1();
        test_clamp();
        test_back_to_back();
        test_reconfig();
        @(negedge clk);
        $display("Checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/vp8_quant_pkg.sv
logic/seq_divider.sv
logic/quant_matrix.sv
logic/quantize_block.sv
logic/quant_unit_top.sv
verif/quant_unit_properties.sv
verif/tb_quant_unit_top.sv
